//--- bridge_pkg.sv
package bridge_pkg;

    // log2 of the transfer size in bytes
    typedef logic [2:0] bus_size_t;

    localparam bus_size_t SIZE_HALF = 3'd1;
    localparam bus_size_t SIZE_WORD = 3'd2;

    // source of the response data
    typedef enum logic [1:0] {
        TGT_ROM,
        TGT_IO,
        TGT_SDRAM
    } mem_target_e;

    // one bus word, or the two halfwords the SDRAM port moves
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } half;
    } mem_word_u;

    // address map
    localparam logic [3:0] IO_REGION = 4'h1;
    localparam int SDRAM_BIT = 27;

    // I/O register offsets
    localparam logic [11:0] REG_TRACE = 12'h000;
    localparam logic [11:0] REG_BG_COLOR = 12'h004;

endpackage

//--- uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       clk_sys,
    input  logic       reset_n,
    input  logic       send_i,
    input  logic [7:0] data_i,
    output logic       busy_o,
    output logic       tx_o
);

    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    // data bits then stop bit, shifted out lsb first
    logic [8:0]       shift;

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            tx_o    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= 4'd0;
        end else if (!busy_o) begin
            if (send_i) begin
                // start bit goes out right away
                shift   <= {1'b1, data_i};
                tx_o    <= 1'b0;
                busy_o  <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= 4'd0;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // end of stop bit, line already idles high
                busy_o <= 1'b0;
            end else begin
                tx_o    <= shift[0];
                shift   <= {1'b1, shift[8:1]};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

//--- io_regs.sv
`timescale 1ns/10ps

module io_regs #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic        clk_sys,
    input  logic        reset_n,
    input  logic        io_wr_i,
    input  logic [11:0] io_offset_i,
    input  logic [31:0] io_wdata_i,
    output logic [31:0] io_rdata_o,
    output logic [23:0] bg_color_o,
    output logic [7:0]  trace_char_o,
    output logic        uart_tx_o
);

    logic trace_wr;
    logic uart_busy;

    assign trace_wr = io_wr_i & (io_offset_i == bridge_pkg::REG_TRACE);

    // status word, busy in bit 0
    assign io_rdata_o = {31'd0, uart_busy};

    always_ff @(posedge clk_sys) begin
        if (trace_wr) begin
            trace_char_o <= io_wdata_i[7:0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            bg_color_o <= 24'd0;
        end else if (io_wr_i && io_offset_i == bridge_pkg::REG_BG_COLOR) begin
            // zero writes are ignored
            if (io_wdata_i != 32'd0) begin
                bg_color_o <= io_wdata_i[23:0];
            end
        end
    end

    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE)
    ) tx_i (
        .clk_sys (clk_sys),
        .reset_n (reset_n),
        .send_i  (trace_wr),
        .data_i  (io_wdata_i[7:0]),
        .busy_o  (uart_busy),
        .tx_o    (uart_tx_o)
    );

endmodule

//--- boot_rom.sv
`timescale 1ns/10ps

module boot_rom #(
    parameter int ROM_ADDR_BITS = 4
) (
    input  logic                     clk_sys,
    input  logic [ROM_ADDR_BITS-1:0] addr_i,
    output logic [31:0]              data_o
);

    logic [31:0] rom [0:(1 << ROM_ADDR_BITS)-1];

    initial begin
        $readmemh("boot_rom.hex", rom);
    end

    // data shows up one cycle after the address
    always_ff @(posedge clk_sys) begin
        data_o <= rom[addr_i];
    end

endmodule

//--- sdram_halfword_port.sv
`timescale 1ns/10ps

module sdram_halfword_port (
    input  logic                  clk_sys,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  logic                  wr_i,
    input  logic                  half_i,
    // halfword address, bit 0 only matters in half mode
    input  logic [23:0]           word_addr_i,
    input  bridge_pkg::mem_word_u wdata_i,
    input  logic                  sdram_rdy_i,
    input  logic [15:0]           sdram_rdata_i,
    output logic                  done_o,
    output bridge_pkg::mem_word_u rdata_o,
    output logic                  sdram_rd_o,
    output logic                  sdram_wr_o,
    output logic [23:0]           sdram_addr_o,
    output logic [15:0]           sdram_wdata_o,
    output logic                  sdram_ack_o
);

    localparam logic [1:0] P_IDLE = 2'd0;
    localparam logic [1:0] P_REQ  = 2'd1;
    localparam logic [1:0] P_ACK  = 2'd2;
    localparam logic [1:0] P_DONE = 2'd3;

    logic [1:0] state;
    logic [1:0] guard;
    logic       hi_phase;

    // the request level stays up for the whole P_REQ state
    assign sdram_rd_o   = (state == P_REQ) & ~wr_i;
    assign sdram_wr_o   = (state == P_REQ) & wr_i;
    assign sdram_ack_o  = (state == P_ACK);
    assign done_o       = (state == P_DONE);

    assign sdram_addr_o  = half_i ? word_addr_i : {word_addr_i[23:1], hi_phase};
    assign sdram_wdata_o = (hi_phase & ~half_i) ? wdata_i.half.hi : wdata_i.half.lo;

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            state    <= P_IDLE;
            guard    <= 2'd0;
            hi_phase <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    hi_phase <= 1'b0;
                    guard    <= 2'd0;
                    if (start_i) begin
                        state <= P_REQ;
                    end
                end
                P_REQ: begin
                    // controller rdy is stale for the first two cycles
                    if (guard != 2'd2) begin
                        guard <= guard + 2'd1;
                    end else if (sdram_rdy_i) begin
                        if (hi_phase) begin
                            rdata_o.half.hi <= sdram_rdata_i;
                        end else begin
                            rdata_o.half.lo <= sdram_rdata_i;
                        end
                        state <= P_ACK;
                    end
                end
                P_ACK: begin
                    guard <= 2'd0;
                    if (!half_i && !hi_phase) begin
                        hi_phase <= 1'b1;
                        state    <= P_REQ;
                    end else begin
                        state <= P_DONE;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

endmodule

//--- bus_sequencer.sv
`timescale 1ns/10ps

module bus_sequencer (
    input  logic                  clk_sys,
    input  logic                  reset_n,
    input  logic                  ibus_cmd_valid_i,
    input  logic [31:0]           ibus_addr_i,
    input  bridge_pkg::bus_size_t ibus_size_i,
    input  logic                  dbus_cmd_valid_i,
    input  logic                  dbus_cmd_wr_i,
    input  logic [31:0]           dbus_addr_i,
    input  logic [31:0]           dbus_wdata_i,
    input  bridge_pkg::bus_size_t dbus_size_i,
    input  logic [31:0]           rom_data_i,
    input  logic [31:0]           io_rdata_i,
    input  logic                  sd_done_i,
    input  bridge_pkg::mem_word_u sd_rdata_i,
    output logic                  dbus_cmd_ready_o,
    output logic                  ibus_rsp_valid_o,
    output logic                  dbus_rsp_valid_o,
    output logic [31:0]           ibus_rsp_data_o,
    output logic [31:0]           dbus_rsp_data_o,
    output logic [29:0]           rom_addr_o,
    output logic                  io_wr_o,
    output logic [11:0]           io_offset_o,
    output logic [31:0]           io_wdata_o,
    output logic                  sd_start_o,
    output logic                  sd_wr_o,
    output logic                  sd_half_o,
    output logic [23:0]           sd_addr_o,
    output bridge_pkg::mem_word_u sd_wdata_o
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_ROM_BURST = 3'd1;
    localparam logic [2:0] S_SD_WAIT   = 3'd2;
    localparam logic [2:0] S_SD_NEXT   = 3'd3;
    localparam logic [2:0] S_FINISH    = 3'd4;

    logic [2:0]              state;
    logic [31:0]             mem_addr;
    logic                    mem_wr;
    logic                    mem_half;
    bridge_pkg::mem_word_u   mem_wdata;
    logic [2:0]              words_rem;
    logic                    for_ibus;
    logic                    rsp_pulse;
    bridge_pkg::mem_target_e target;
    logic [31:0]             rsp_data;

    // command seen this cycle, data bus first
    logic [31:0]           sel_addr;
    bridge_pkg::bus_size_t sel_size;
    logic                  sel_wr;
    logic                  accept;
    logic                  is_sdram;
    logic                  is_io;
    logic [2:0]            burst_rem;

    assign sel_addr = dbus_cmd_valid_i ? dbus_addr_i : ibus_addr_i;
    assign sel_size = dbus_cmd_valid_i ? dbus_size_i : ibus_size_i;
    assign sel_wr   = dbus_cmd_valid_i & dbus_cmd_wr_i;
    assign accept   = (state == S_IDLE) & (dbus_cmd_valid_i | ibus_cmd_valid_i);
    assign is_sdram = sel_addr[bridge_pkg::SDRAM_BIT];
    assign is_io    = (sel_addr[27:24] == bridge_pkg::IO_REGION);

    // words after the first one in a burst
    assign burst_rem = (sel_size > bridge_pkg::SIZE_WORD) ?
                       3'((4'd1 << (sel_size - bridge_pkg::SIZE_WORD)) - 4'd1) : 3'd0;

    // ready drops in the same cycle a command is taken
    assign dbus_cmd_ready_o = (state == S_IDLE);

    // I/O writes go straight through on the accepting cycle
    assign io_wr_o     = accept & sel_wr & is_io;
    assign io_offset_o = dbus_addr_i[11:0];
    assign io_wdata_o  = dbus_wdata_i;

    assign rom_addr_o = mem_addr[31:2];

    assign sd_start_o = (state == S_SD_WAIT);
    assign sd_wr_o    = mem_wr;
    assign sd_half_o  = mem_half;
    assign sd_addr_o  = mem_addr[24:1];
    assign sd_wdata_o = mem_wdata;

    always_comb begin
        case (target)
            bridge_pkg::TGT_IO:    rsp_data = io_rdata_i;
            bridge_pkg::TGT_SDRAM: rsp_data = sd_rdata_i.word;
            default:               rsp_data = rom_data_i;
        endcase
    end

    assign ibus_rsp_valid_o = rsp_pulse & for_ibus;
    assign dbus_rsp_valid_o = rsp_pulse & ~for_ibus;
    assign ibus_rsp_data_o  = rsp_data;
    assign dbus_rsp_data_o  = rsp_data;

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            state     <= S_IDLE;
            rsp_pulse <= 1'b0;
            for_ibus  <= 1'b0;
            target    <= bridge_pkg::TGT_ROM;
            words_rem <= 3'd0;
        end else begin
            rsp_pulse <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        mem_addr       <= sel_addr;
                        mem_wr         <= sel_wr;
                        mem_half       <= (sel_size == bridge_pkg::SIZE_HALF);
                        for_ibus       <= ~dbus_cmd_valid_i;
                        words_rem      <= burst_rem;
                        mem_wdata.word <= dbus_wdata_i;
                        // a halfword write travels in the low half, picked by address bit 1
                        if (sel_size == bridge_pkg::SIZE_HALF) begin
                            mem_wdata.half.lo <= dbus_addr_i[1] ? dbus_wdata_i[31:16]
                                                                : dbus_wdata_i[15:0];
                        end
                        if (is_sdram) begin
                            target <= bridge_pkg::TGT_SDRAM;
                            state  <= S_SD_WAIT;
                        end else if (is_io) begin
                            target    <= bridge_pkg::TGT_IO;
                            rsp_pulse <= ~sel_wr;
                            state     <= S_FINISH;
                        end else begin
                            // ROM writes are dropped
                            target <= bridge_pkg::TGT_ROM;
                            state  <= sel_wr ? S_FINISH : S_ROM_BURST;
                        end
                    end
                end
                S_ROM_BURST: begin
                    rsp_pulse <= 1'b1;
                    mem_addr  <= mem_addr + 32'd4;
                    words_rem <= words_rem - 3'd1;
                    if (words_rem == 3'd0) begin
                        state <= S_FINISH;
                    end
                end
                S_SD_WAIT: begin
                    if (sd_done_i) begin
                        rsp_pulse <= ~mem_wr;
                        if (mem_wr || words_rem == 3'd0) begin
                            state <= S_FINISH;
                        end else begin
                            state <= S_SD_NEXT;
                        end
                    end
                end
                S_SD_NEXT: begin
                    // start is low here so the port sees a fresh request
                    mem_addr  <= mem_addr + 32'd4;
                    words_rem <= words_rem - 3'd1;
                    state     <= S_SD_WAIT;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- mem_bridge.sv
`timescale 1ns/10ps

module mem_bridge #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int ROM_ADDR_BITS = 4
) (
    input  logic                  clk_sys,
    input  logic                  reset_n,

    // instruction bus
    input  logic                  ibus_cmd_valid_i,
    input  logic [31:0]           ibus_addr_i,
    input  bridge_pkg::bus_size_t ibus_size_i,
    output logic                  ibus_rsp_valid_o,
    output logic [31:0]           ibus_rsp_data_o,

    // data bus
    input  logic                  dbus_cmd_valid_i,
    input  logic                  dbus_cmd_wr_i,
    input  logic [31:0]           dbus_addr_i,
    input  logic [31:0]           dbus_wdata_i,
    input  bridge_pkg::bus_size_t dbus_size_i,
    output logic                  dbus_cmd_ready_o,
    output logic                  dbus_rsp_valid_o,
    output logic [31:0]           dbus_rsp_data_o,

    // SDRAM controller halfword port
    output logic                  sdram_rd_o,
    output logic                  sdram_wr_o,
    output logic [23:0]           sdram_addr_o,
    output logic [15:0]           sdram_wdata_o,
    input  logic                  sdram_rdy_i,
    input  logic [15:0]           sdram_rdata_i,
    output logic                  sdram_ack_o,

    output logic                  uart_tx_o,
    output logic [23:0]           bg_color_o,
    output logic [7:0]            trace_char_o
);

    logic [29:0]           rom_word_addr;
    logic [31:0]           rom_data;
    logic [31:0]           io_rdata;
    logic                  io_wr;
    logic [11:0]           io_offset;
    logic [31:0]           io_wdata;
    logic                  sd_start;
    logic                  sd_wr;
    logic                  sd_half;
    logic [23:0]           sd_addr;
    bridge_pkg::mem_word_u sd_wdata;
    bridge_pkg::mem_word_u sd_rdata;
    logic                  sd_done;

    bus_sequencer seq_i (
        .clk_sys          (clk_sys),
        .reset_n          (reset_n),
        .ibus_cmd_valid_i (ibus_cmd_valid_i),
        .ibus_addr_i      (ibus_addr_i),
        .ibus_size_i      (ibus_size_i),
        .dbus_cmd_valid_i (dbus_cmd_valid_i),
        .dbus_cmd_wr_i    (dbus_cmd_wr_i),
        .dbus_addr_i      (dbus_addr_i),
        .dbus_wdata_i     (dbus_wdata_i),
        .dbus_size_i      (dbus_size_i),
        .rom_data_i       (rom_data),
        .io_rdata_i       (io_rdata),
        .sd_done_i        (sd_done),
        .sd_rdata_i       (sd_rdata),
        .dbus_cmd_ready_o (dbus_cmd_ready_o),
        .ibus_rsp_valid_o (ibus_rsp_valid_o),
        .dbus_rsp_valid_o (dbus_rsp_valid_o),
        .ibus_rsp_data_o  (ibus_rsp_data_o),
        .dbus_rsp_data_o  (dbus_rsp_data_o),
        .rom_addr_o       (rom_word_addr),
        .io_wr_o          (io_wr),
        .io_offset_o      (io_offset),
        .io_wdata_o       (io_wdata),
        .sd_start_o       (sd_start),
        .sd_wr_o          (sd_wr),
        .sd_half_o        (sd_half),
        .sd_addr_o        (sd_addr),
        .sd_wdata_o       (sd_wdata)
    );

    sdram_halfword_port sd_port_i (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .start_i       (sd_start),
        .wr_i          (sd_wr),
        .half_i        (sd_half),
        .word_addr_i   (sd_addr),
        .wdata_i       (sd_wdata),
        .sdram_rdy_i   (sdram_rdy_i),
        .sdram_rdata_i (sdram_rdata_i),
        .done_o        (sd_done),
        .rdata_o       (sd_rdata),
        .sdram_rd_o    (sdram_rd_o),
        .sdram_wr_o    (sdram_wr_o),
        .sdram_addr_o  (sdram_addr_o),
        .sdram_wdata_o (sdram_wdata_o),
        .sdram_ack_o   (sdram_ack_o)
    );

    // the ROM address wraps modulo its depth
    boot_rom #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) rom_i (
        .clk_sys (clk_sys),
        .addr_i  (rom_word_addr[ROM_ADDR_BITS-1:0]),
        .data_o  (rom_data)
    );

    io_regs #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE)
    ) io_i (
        .clk_sys      (clk_sys),
        .reset_n      (reset_n),
        .io_wr_i      (io_wr),
        .io_offset_i  (io_offset),
        .io_wdata_i   (io_wdata),
        .io_rdata_o   (io_rdata),
        .bg_color_o   (bg_color_o),
        .trace_char_o (trace_char_o),
        .uart_tx_o    (uart_tx_o)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_sys,
    output logic reset_n
);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk_sys);
        reset_n <= 1'b1;
    end

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/10ps

module tb_sdram_model (
    input  logic        clk_sys,
    input  logic        reset_n,
    input  logic        sdram_rd_i,
    input  logic        sdram_wr_i,
    input  logic [23:0] sdram_addr_i,
    input  logic [15:0] sdram_wdata_i,
    input  logic        sdram_ack_i,
    output logic        sdram_rdy_o,
    output logic [15:0] sdram_rdata_o
);

    logic [15:0] mem [0:1023];
    integer      seed;
    integer      delay;
    integer      wait_cnt;

    initial begin
        seed = 32'h5d96_ca79;
        delay = 2 + ($unsigned($random(seed)) % 5);
        wait_cnt = 0;
        sdram_rdy_o = 1'b0;
        // fill pattern from the whole halfword address
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
        end
    end

    assign sdram_rdata_o = mem[sdram_addr_i[9:0]];

    always @(posedge clk_sys) begin
        if (!reset_n) begin
            sdram_rdy_o <= 1'b0;
            wait_cnt = 0;
        end else if (sdram_ack_i) begin
            sdram_rdy_o <= 1'b0;
            wait_cnt = 0;
            delay = 2 + ($unsigned($random(seed)) % 5);
        end else if (sdram_rd_i || sdram_wr_i) begin
            wait_cnt = wait_cnt + 1;
            sdram_rdy_o <= (wait_cnt >= delay);
        end
    end

    // remember the op of the current request so ack knows a write happened
    logic last_wr;

    always @(posedge clk_sys) begin
        if (sdram_rd_i || sdram_wr_i) begin
            last_wr <= sdram_wr_i;
        end
        if (sdram_ack_i && last_wr) begin
            mem[sdram_addr_i[9:0]] <= sdram_wdata_i;
        end
    end

endmodule

//--- mem_bridge_chk.sv
`timescale 1ns/10ps

module mem_bridge_chk (
    input logic clk_sys,
    input logic reset_n,
    input logic ibus_rsp_valid_o,
    input logic dbus_rsp_valid_o,
    input logic dbus_cmd_ready_o,
    input logic sdram_rd_o,
    input logic sdram_wr_o,
    input logic sdram_rdy_i,
    input logic sdram_ack_o
);

    // a request level covers the two-cycle guard before rdy counts
    a_req_guard: assert property (@(posedge clk_sys) disable iff (!reset_n)
        $rose(sdram_rd_o || sdram_wr_o) |-> (sdram_rd_o || sdram_wr_o)[*3])
        else $error("sdram request level dropped inside the two-cycle guard");

    // the controller stalls the bridge by holding rdy low
    a_req_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
        (sdram_rd_o || sdram_wr_o) && !sdram_rdy_i |=> (sdram_rd_o || sdram_wr_o))
        else $error("sdram request level dropped while rdy was low");

    // strobes only come while a command is in flight
    a_rsp_busy: assert property (@(posedge clk_sys) disable iff (!reset_n)
        (ibus_rsp_valid_o || dbus_rsp_valid_o) |-> !dbus_cmd_ready_o)
        else $error("response strobe while the bridge is idle");

    a_rd_wr: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !(sdram_rd_o && sdram_wr_o))
        else $error("sdram read and write requests high together");

    a_ack_req: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdram_ack_o |-> !(sdram_rd_o || sdram_wr_o))
        else $error("sdram ack while a request level is high");

endmodule

bind mem_bridge mem_bridge_chk chk_i (.*);

//--- tb_mem_bridge.sv
`timescale 1ns/10ps

module tb_mem_bridge;

    localparam int TIMEOUT = 200;

    logic                  clk_sys;
    logic                  reset_n;
    logic                  ibus_cmd_valid_i;
    logic [31:0]           ibus_addr_i;
    bridge_pkg::bus_size_t ibus_size_i;
    logic                  ibus_rsp_valid_o;
    logic [31:0]           ibus_rsp_data_o;
    logic                  dbus_cmd_valid_i;
    logic                  dbus_cmd_wr_i;
    logic [31:0]           dbus_addr_i;
    logic [31:0]           dbus_wdata_i;
    bridge_pkg::bus_size_t dbus_size_i;
    logic                  dbus_cmd_ready_o;
    logic                  dbus_rsp_valid_o;
    logic [31:0]           dbus_rsp_data_o;
    logic                  sdram_rd_o;
    logic                  sdram_wr_o;
    logic [23:0]           sdram_addr_o;
    logic [15:0]           sdram_wdata_o;
    logic                  sdram_rdy_i;
    logic [15:0]           sdram_rdata_i;
    logic                  sdram_ack_o;
    logic                  uart_tx_o;
    logic [23:0]           bg_color_o;
    logic [7:0]            trace_char_o;

    logic [31:0] rom_exp [0:15];
    int          errors;
    int          timeouts;

    // stimulus table
    int                    n_rows;
    bit                    row_ibus  [0:15];
    bit                    row_wr    [0:15];
    logic [31:0]           row_addr  [0:15];
    bridge_pkg::bus_size_t row_size  [0:15];
    logic [31:0]           row_wdata [0:15];
    logic [31:0]           row_exp   [0:15][0:3];

    tb_clock_gen clk_gen_i (
        .clk_sys (clk_sys),
        .reset_n (reset_n)
    );

    mem_bridge #(
        .CLK_FREQ_HZ (25_000_000),
        .BAUD_RATE   (3_125_000)
    ) mem_bridge_i (.*);

    tb_sdram_model sdram_i (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .sdram_rd_i    (sdram_rd_o),
        .sdram_wr_i    (sdram_wr_o),
        .sdram_addr_i  (sdram_addr_o),
        .sdram_wdata_i (sdram_wdata_o),
        .sdram_ack_i   (sdram_ack_o),
        .sdram_rdy_o   (sdram_rdy_i),
        .sdram_rdata_o (sdram_rdata_i)
    );

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_color(input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            $display("FAIL bg_color_o got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input bit ibus, input bit wr, input logic [31:0] addr,
                           input bridge_pkg::bus_size_t size, input logic [31:0] wdata,
                           input logic [31:0] e0, input logic [31:0] e1,
                           input logic [31:0] e2, input logic [31:0] e3);
        row_ibus[n_rows]   = ibus;
        row_wr[n_rows]     = wr;
        row_addr[n_rows]   = addr;
        row_size[n_rows]   = size;
        row_wdata[n_rows]  = wdata;
        row_exp[n_rows][0] = e0;
        row_exp[n_rows][1] = e1;
        row_exp[n_rows][2] = e2;
        row_exp[n_rows][3] = e3;
        n_rows++;
    endtask

    task automatic wait_ready();
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk_sys);
            cnt++;
        end while (!dbus_cmd_ready_o && cnt < TIMEOUT);
        if (!dbus_cmd_ready_o) begin
            $display("timeout waiting for the bridge to become ready");
            timeouts++;
        end
    endtask

    // issue one command, then collect and check its responses
    task automatic issue_cmd(input bit ibus, input bit wr, input logic [31:0] addr,
                             input bridge_pkg::bus_size_t size, input logic [31:0] wdata,
                             input logic [31:0] exp [0:3], input string tag);
        int n_rsp;
        int cnt;
        logic strobe;
        logic [31:0] data;
        n_rsp = wr ? 0 : ((size <= bridge_pkg::SIZE_WORD) ? 1 : (1 << (size - 2)));
        @(posedge clk_sys);
        if (ibus) begin
            ibus_cmd_valid_i <= 1'b1;
            ibus_addr_i      <= addr;
            ibus_size_i      <= size;
        end else begin
            dbus_cmd_valid_i <= 1'b1;
            dbus_cmd_wr_i    <= wr;
            dbus_addr_i      <= addr;
            dbus_size_i      <= size;
            dbus_wdata_i     <= wdata;
        end
        wait_ready();
        // the bridge takes the command on this edge
        @(posedge clk_sys);
        ibus_cmd_valid_i <= 1'b0;
        dbus_cmd_valid_i <= 1'b0;
        for (int k = 0; k < n_rsp; k++) begin
            cnt = 0;
            do begin
                @(negedge clk_sys);
                cnt++;
                strobe = ibus ? ibus_rsp_valid_o : dbus_rsp_valid_o;
            end while (!strobe && cnt < TIMEOUT);
            if (!strobe) begin
                $display("timeout waiting for response %0d of %s", k, tag);
                timeouts++;
            end else begin
                data = ibus ? ibus_rsp_data_o : dbus_rsp_data_o;
                check_word(ibus ? "ibus_rsp_data_o" : "dbus_rsp_data_o", data, exp[k]);
            end
        end
        wait_ready();
    endtask

    task automatic io_read(input logic [31:0] exp);
        logic [31:0] e [0:3];
        e = '{exp, 32'd0, 32'd0, 32'd0};
        issue_cmd(1'b0, 1'b0, 32'h0100_0008, bridge_pkg::SIZE_WORD, 32'd0, e, "io read");
    endtask

    task automatic decode_serial(output logic [7:0] ch);
        int cnt;
        cnt = 0;
        while (uart_tx_o !== 1'b0 && cnt < TIMEOUT) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (uart_tx_o !== 1'b0) begin
            $display("timeout waiting for the serial start bit");
            timeouts++;
            ch = 8'hxx;
        end else begin
            // move to the middle of the start bit
            repeat (3) @(negedge clk_sys);
            if (uart_tx_o !== 1'b0) begin
                $display("serial start bit too short");
                errors++;
            end
            for (int b = 0; b < 8; b++) begin
                repeat (8) @(negedge clk_sys);
                ch[b] = uart_tx_o;
            end
            repeat (8) @(negedge clk_sys);
            if (uart_tx_o !== 1'b1) begin
                $display("serial stop bit missing");
                errors++;
            end
        end
    endtask

    initial begin
        logic [7:0]  rx_char;
        logic [31:0] e [0:3];
        int          reset_wait;
        ibus_cmd_valid_i = 1'b0;
        ibus_addr_i      = 32'd0;
        ibus_size_i      = bridge_pkg::SIZE_WORD;
        dbus_cmd_valid_i = 1'b0;
        dbus_cmd_wr_i    = 1'b0;
        dbus_addr_i      = 32'd0;
        dbus_wdata_i     = 32'd0;
        dbus_size_i      = bridge_pkg::SIZE_WORD;
        errors     = 0;
        timeouts   = 0;
        n_rows     = 0;
        reset_wait = 0;
        $readmemh("boot_rom.hex", rom_exp);

        // ROM bursts, word 14 onward wraps to word 0
        add_row(1, 0, 32'h0000_0038, 3'd4, 0, rom_exp[14], rom_exp[15], rom_exp[0], rom_exp[1]);
        add_row(0, 0, 32'h0000_0010, 3'd2, 0, rom_exp[4], 0, 0, 0);
        add_row(0, 1, 32'h0000_0020, 3'd2, 32'h1111_2222, 0, 0, 0, 0);
        // SDRAM words, then a halfword into the upper half of the first one
        add_row(0, 1, 32'h0800_0100, 3'd2, 32'h1234_5678, 0, 0, 0, 0);
        add_row(0, 1, 32'h0800_0104, 3'd2, 32'h9abc_def0, 0, 0, 0, 0);
        add_row(0, 0, 32'h0800_0100, 3'd2, 0, 32'h1234_5678, 0, 0, 0);
        add_row(0, 0, 32'h0800_0104, 3'd2, 0, 32'h9abc_def0, 0, 0, 0);
        add_row(0, 1, 32'h0800_0102, 3'd1, 32'hbeef_0000, 0, 0, 0, 0);
        add_row(0, 0, 32'h0800_0100, 3'd2, 0, 32'hbeef_5678, 0, 0, 0);
        add_row(0, 1, 32'h0800_0106, 3'd1, 32'hc0de_ffff, 0, 0, 0, 0);
        add_row(0, 0, 32'h0800_0100, 3'd3, 0, 32'hbeef_5678, 32'hc0de_def0, 0, 0);

        while (reset_n !== 1'b1 && reset_wait < TIMEOUT) begin
            @(negedge clk_sys);
            reset_wait++;
        end
        if (reset_n !== 1'b1) begin
            $display("timeout waiting for reset to be released");
            timeouts++;
        end
        @(negedge clk_sys);
        if (dbus_cmd_ready_o !== 1'b1 || ibus_rsp_valid_o !== 1'b0 ||
            dbus_rsp_valid_o !== 1'b0 || uart_tx_o !== 1'b1) begin
            $display("FAIL dbus_cmd_ready_o %h ibus_rsp_valid_o %h dbus_rsp_valid_o %h %s",
                     dbus_cmd_ready_o, ibus_rsp_valid_o, dbus_rsp_valid_o,
                     $sformatf("uart_tx_o %h after reset, expected 1 0 0 1", uart_tx_o));
            errors++;
        end
        check_color(bg_color_o, 24'h000000);

        for (int r = 0; r < n_rows; r++) begin
            e = row_exp[r];
            issue_cmd(row_ibus[r], row_wr[r], row_addr[r], row_size[r], row_wdata[r],
                      e, $sformatf("row %0d", r));
        end

        // background colour, zero writes are ignored
        e = '{32'd0, 32'd0, 32'd0, 32'd0};
        issue_cmd(0, 1, 32'h0100_0004, 3'd2, 32'hff12_3456, e, "colour write");
        check_color(bg_color_o, 24'h123456);
        issue_cmd(0, 1, 32'h0100_0004, 3'd2, 32'h0000_0000, e, "colour zero write");
        check_color(bg_color_o, 24'h123456);

        // trace character, busy while the frame is on the line
        issue_cmd(0, 1, 32'h0100_0000, 3'd2, 32'h0000_004b, e, "trace write");
        fork
            decode_serial(rx_char);
            io_read(32'd1);
        join
        check_char("trace_char_o", trace_char_o, 8'h4b);
        check_char("uart_tx_o byte", rx_char, 8'h4b);
        repeat (8) @(negedge clk_sys);
        io_read(32'd0);

        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- boot_rom.hex
// one 32-bit ROM word per line, word address 0 first
00000297
02028293
30529073
00001137
ff010113
0080006f
deadbeef
c0ffee00
13579bdf
2468ace0
0f1e2d3c
4b5a6978
8796a5b4
c3d2e1f0
a5a5f00d
5a5a0ff1

//--- sim.f
bridge_pkg.sv
uart_tx.sv
io_regs.sv
boot_rom.sv
sdram_halfword_port.sv
bus_sequencer.sv
mem_bridge.sv
tb_clock_gen.sv
tb_sdram_model.sv
mem_bridge_chk.sv
tb_mem_bridge.sv
